// ==== source/sv32_pkg.sv ====
`default_nettype none

package sv32_pkg;

    localparam int PAGE_OFFSET_W = 12;
    localparam int PA_W          = 34;
    localparam int PTE_BYTES     = 4;

    typedef enum logic [1:0] {
        PRV_U = 2'b00,
        PRV_S = 2'b01,
        PRV_M = 2'b11
    } prv_e;

    typedef enum logic [1:0] {
        ACC_READ  = 2'b00,
        ACC_WRITE = 2'b01,
        ACC_EXEC  = 2'b10
    } access_e;

    typedef enum logic {
        MODE_BARE = 1'b0,
        MODE_SV32 = 1'b1
    } satp_mode_e;

    typedef enum logic [1:0] {
        W_IDLE = 2'b00,
        W_REQ  = 2'b01,
        W_PTE  = 2'b10,
        W_DONE = 2'b11
    } walk_state_e;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } sv32_pte_t;

    // prv is the effective level after mprv
    typedef struct packed {
        logic [9:0]               vpn1;
        logic [9:0]               vpn0;
        logic [PAGE_OFFSET_W-1:0] offset;
        access_e                  access;
        prv_e                     prv;
        logic                     sum;
        logic                     translate;
    } mmu_req_t;

endpackage

`default_nettype wire

// ==== source/mem_rd_pkg.sv ====
`default_nettype none

package mem_rd_pkg;

    // address phase held until ar_ready
    typedef struct packed {
        logic [sv32_pkg::PA_W-1:0] addr;
        logic                      valid;
    } mem_rd_req_t;

    // single-beat response with rready tied high
    typedef struct packed {
        logic [31:0] data;
        logic        err;
        logic        valid;
    } mem_rd_rsp_t;

endpackage

`default_nettype wire

// ==== source/mmu_req_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_req_capture (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     va_valid,
    input  wire [31:0]              va,
    input  wire                     access_w,
    input  wire                     access_x,
    input  sv32_pkg::prv_e          prv,
    input  wire                     mprv,
    input  sv32_pkg::prv_e          mpp,
    input  wire                     sum,
    input  sv32_pkg::satp_mode_e    satp_mode,
    input  wire                     busy,
    output logic                    va_ready,
    output logic                    accept,
    output sv32_pkg::mmu_req_t      req_now,
    output sv32_pkg::mmu_req_t      req_held
);

    import sv32_pkg::*;

    access_e access_op;
    prv_e    eff_prv;

    // execute wins over write
    assign access_op = access_x ? ACC_EXEC : (access_w ? ACC_WRITE : ACC_READ);

    // mprv does not apply to fetches
    assign eff_prv = (mprv && access_op != ACC_EXEC) ? mpp : prv;

    assign va_ready = ~busy;
    assign accept   = va_valid & va_ready;

    always_comb begin
        req_now.vpn1      = va[31:22];
        req_now.vpn0      = va[21:12];
        req_now.offset    = va[PAGE_OFFSET_W-1:0];
        req_now.access    = access_op;
        req_now.prv       = eff_prv;
        req_now.sum       = sum;
        req_now.translate = (eff_prv != PRV_M) && (satp_mode == MODE_SV32);
    end

    // kept for the walk and the result
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_held <= '0;
        end else if (accept) begin
            req_held <= req_now;
        end
    end

endmodule

`default_nettype wire

// ==== source/mmu_last_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_last_entry (
    input  wire                     clk,
    input  wire                     rstn,
    input  sv32_pkg::mmu_req_t      req_now,
    input  wire                     flush,
    input  wire                     fill,
    input  wire [9:0]               fill_vpn1,
    input  wire [9:0]               fill_vpn0,
    input  wire                     fill_super,
    input  sv32_pkg::sv32_pte_t     fill_pte,
    output logic                    hit,
    output sv32_pkg::sv32_pte_t     hit_pte,
    output logic                    hit_super
);

    import sv32_pkg::*;

    logic      entry_valid;
    logic [9:0] entry_vpn1;
    logic [9:0] entry_vpn0;
    logic      entry_super;
    sv32_pte_t entry_pte;
    logic      vpn1_match;
    logic      vpn0_match;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entry_valid <= 1'b0;
        end else if (flush) begin
            entry_valid <= 1'b0;
        end else if (fill) begin
            entry_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            entry_vpn1  <= fill_vpn1;
            entry_vpn0  <= fill_vpn0;
            entry_super <= fill_super;
            entry_pte   <= fill_pte;
        end
    end

    assign vpn1_match = (entry_vpn1 == req_now.vpn1);
    // a superpage covers every vpn0
    assign vpn0_match = entry_super || (entry_vpn0 == req_now.vpn0);

    assign hit       = entry_valid && req_now.translate && vpn1_match && vpn0_match;
    assign hit_pte   = entry_pte;
    assign hit_super = entry_super;

endmodule

`default_nettype wire

// ==== source/mmu_pte_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_pte_check (
    input  sv32_pkg::sv32_pte_t pte,
    input  wire                 level0,
    input  sv32_pkg::mmu_req_t  req,
    output logic                leaf,
    output logic                fault
);

    import sv32_pkg::*;

    logic is_exec;
    logic is_write;
    logic is_read;
    logic bad_format;
    logic misaligned;
    logic perm_bad;
    logic priv_bad;
    logic ad_bad;

    assign is_exec  = (req.access == ACC_EXEC);
    assign is_write = (req.access == ACC_WRITE);
    assign is_read  = (req.access == ACC_READ);

    assign leaf = pte.v && (pte.r || pte.x);

    // pointer at level 0 is also malformed
    assign bad_format = !pte.v || (pte.w && !pte.r) || (!leaf && level0);

    // superpage must be 4 MiB aligned
    assign misaligned = !level0 && (|pte.ppn0);

    assign perm_bad = (is_exec && !pte.x) || (is_read && !pte.r) || (is_write && !pte.w);

    assign priv_bad = (req.prv == PRV_U && !pte.u) ||
                      (req.prv == PRV_S && pte.u && (!req.sum || is_exec));

    // no hardware a/d update
    assign ad_bad = !pte.a || (is_write && !pte.d);

    assign fault = bad_format || (leaf && (misaligned || perm_bad || priv_bad || ad_bad));

endmodule

`default_nettype wire

// ==== source/mmu_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_walker (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         start,
    input  sv32_pkg::mmu_req_t          req,
    input  wire [21:0]                  satp_ppn,
    input  wire                         ar_ready,
    input  mem_rd_pkg::mem_rd_rsp_t     rd_rsp,
    output mem_rd_pkg::mem_rd_req_t     rd_req,
    output logic                        busy,
    output logic                        done,
    output sv32_pkg::sv32_pte_t         done_pte,
    output logic                        done_super,
    output logic                        page_fault,
    output logic                        bus_err,
    output logic                        fill
);

    import sv32_pkg::*;

    walk_state_e state;
    logic        level0;
    logic        ar_sent;
    logic [21:0] table_ppn;
    sv32_pte_t   pte_q;
    logic        fault_q;
    logic        bus_err_q;
    logic [9:0]  vpn_idx;
    logic        rsp_ok;
    logic        pte_leaf;
    logic        pte_fault;

    mmu_pte_check u_pte_check (
        .pte    (pte_q),
        .level0 (level0),
        .req    (req),
        .leaf   (pte_leaf),
        .fault  (pte_fault)
    );

    assign vpn_idx = level0 ? req.vpn0 : req.vpn1;

    always_comb begin
        rd_req.addr  = {table_ppn, {PAGE_OFFSET_W{1'b0}}} + PA_W'(vpn_idx * PTE_BYTES);
        rd_req.valid = (state == W_REQ) && !ar_sent;
    end

    // only count a response once the address went out
    assign rsp_ok = rd_rsp.valid && ar_sent;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= W_IDLE;
            level0    <= 1'b0;
            ar_sent   <= 1'b0;
            fault_q   <= 1'b0;
            bus_err_q <= 1'b0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start) begin
                        state     <= W_REQ;
                        level0    <= 1'b0;
                        fault_q   <= 1'b0;
                        bus_err_q <= 1'b0;
                    end
                end
                W_REQ: begin
                    if (rd_req.valid && ar_ready) begin
                        ar_sent <= 1'b1;
                    end
                    if (rsp_ok) begin
                        ar_sent   <= 1'b0;
                        bus_err_q <= rd_rsp.err;
                        state     <= rd_rsp.err ? W_DONE : W_PTE;
                    end
                end
                W_PTE: begin
                    if (pte_fault) begin
                        fault_q <= 1'b1;
                        state   <= W_DONE;
                    end else if (pte_leaf) begin
                        state <= W_DONE;
                    end else begin
                        // descend to the second level
                        level0 <= 1'b1;
                        state  <= W_REQ;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_IDLE && start) begin
            table_ppn <= satp_ppn;
        end else if (state == W_PTE && !pte_fault && !pte_leaf) begin
            table_ppn <= {pte_q.ppn1, pte_q.ppn0};
        end
        if (state == W_REQ && rsp_ok && !rd_rsp.err) begin
            pte_q <= sv32_pte_t'(rd_rsp.data);
        end
    end

    assign busy       = (state != W_IDLE);
    assign done       = (state == W_DONE);
    assign done_pte   = pte_q;
    assign done_super = !level0;
    assign page_fault = fault_q;
    assign bus_err    = bus_err_q;
    // reaching done without an error means a good leaf
    assign fill       = done && !fault_q && !bus_err_q;

endmodule

`default_nettype wire

// ==== source/mmu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_result (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         direct,
    input  sv32_pkg::mmu_req_t          direct_req,
    input  sv32_pkg::sv32_pte_t         direct_pte,
    input  wire                         direct_super,
    input  wire                         direct_fault,
    input  wire                         walk_done,
    input  sv32_pkg::mmu_req_t          walk_req,
    input  sv32_pkg::sv32_pte_t         walk_pte,
    input  wire                         walk_super,
    input  wire                         page_fault,
    input  wire                         bus_err,
    output logic                        pa_valid,
    output logic [sv32_pkg::PA_W-1:0]   pa,
    output logic [1:0]                  pa_bad
);

    import sv32_pkg::*;

    mmu_req_t        sel_req;
    sv32_pte_t       sel_pte;
    logic            sel_super;
    logic            sel_fault;
    logic            sel_berr;
    logic [PA_W-1:0] pa_d;

    // direct and walk strobes never overlap
    assign sel_req   = direct ? direct_req   : walk_req;
    assign sel_pte   = direct ? direct_pte   : walk_pte;
    assign sel_super = direct ? direct_super : walk_super;
    assign sel_fault = direct ? direct_fault : page_fault;
    assign sel_berr  = direct ? 1'b0         : bus_err;

    always_comb begin
        if (!sel_req.translate) begin
            pa_d = {2'b00, sel_req.vpn1, sel_req.vpn0, sel_req.offset};
        end else if (sel_super) begin
            pa_d = {sel_pte.ppn1, sel_req.vpn0, sel_req.offset};
        end else begin
            pa_d = {sel_pte.ppn1, sel_pte.ppn0, sel_req.offset};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pa_valid <= 1'b0;
        end else begin
            pa_valid <= direct || walk_done;
        end
    end

    // bus error only reported without a page fault
    always_ff @(posedge clk) begin
        if (direct || walk_done) begin
            pa     <= pa_d;
            pa_bad <= {sel_berr && !sel_fault, sel_fault};
        end
    end

endmodule

`default_nettype wire

// ==== source/mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         va_valid,
    input  wire [31:0]                  va,
    input  wire                         access_w,
    input  wire                         access_x,
    input  sv32_pkg::prv_e              prv,
    input  wire                         mprv,
    input  sv32_pkg::prv_e              mpp,
    input  wire                         sum,
    input  sv32_pkg::satp_mode_e        satp_mode,
    input  wire [21:0]                  satp_ppn,
    input  wire                         flush,
    input  wire                         mem_rd_ar_ready,
    input  mem_rd_pkg::mem_rd_rsp_t     mem_rd_rsp,
    output logic                        va_ready,
    output mem_rd_pkg::mem_rd_req_t     mem_rd_req,
    output logic                        pa_valid,
    output logic [sv32_pkg::PA_W-1:0]   pa,
    output logic [1:0]                  pa_bad
);

    import sv32_pkg::*;

    logic      accept;
    logic      busy;
    mmu_req_t  req_now;
    mmu_req_t  req_held;
    logic      hit;
    sv32_pte_t hit_pte;
    logic      hit_super;
    logic      hit_fault;
    logic      walk_start;
    logic      direct;
    logic      direct_fault;
    logic      walk_done;
    sv32_pte_t walk_pte;
    logic      walk_super;
    logic      walk_page_fault;
    logic      walk_bus_err;
    logic      walk_fill;

    mmu_req_capture u_capture (
        .clk       (clk),
        .rstn      (rstn),
        .va_valid  (va_valid),
        .va        (va),
        .access_w  (access_w),
        .access_x  (access_x),
        .prv       (prv),
        .mprv      (mprv),
        .mpp       (mpp),
        .sum       (sum),
        .satp_mode (satp_mode),
        .busy      (busy),
        .va_ready  (va_ready),
        .accept    (accept),
        .req_now   (req_now),
        .req_held  (req_held)
    );

    mmu_last_entry u_last_entry (
        .clk        (clk),
        .rstn       (rstn),
        .req_now    (req_now),
        .flush      (flush),
        .fill       (walk_fill),
        .fill_vpn1  (req_held.vpn1),
        .fill_vpn0  (req_held.vpn0),
        .fill_super (walk_super),
        .fill_pte   (walk_pte),
        .hit        (hit),
        .hit_pte    (hit_pte),
        .hit_super  (hit_super)
    );

    // permissions of the cached leaf are rechecked per access
    mmu_pte_check u_hit_check (
        .pte    (hit_pte),
        .level0 (!hit_super),
        .req    (req_now),
        .leaf   (),
        .fault  (hit_fault)
    );

    assign walk_start   = accept && req_now.translate && !hit;
    assign direct       = accept && (!req_now.translate || hit);
    assign direct_fault = hit && hit_fault;

    mmu_walker u_walker (
        .clk        (clk),
        .rstn       (rstn),
        .start      (walk_start),
        .req        (req_held),
        .satp_ppn   (satp_ppn),
        .ar_ready   (mem_rd_ar_ready),
        .rd_rsp     (mem_rd_rsp),
        .rd_req     (mem_rd_req),
        .busy       (busy),
        .done       (walk_done),
        .done_pte   (walk_pte),
        .done_super (walk_super),
        .page_fault (walk_page_fault),
        .bus_err    (walk_bus_err),
        .fill       (walk_fill)
    );

    mmu_result u_result (
        .clk          (clk),
        .rstn         (rstn),
        .direct       (direct),
        .direct_req   (req_now),
        .direct_pte   (hit_pte),
        .direct_super (hit_super),
        .direct_fault (direct_fault),
        .walk_done    (walk_done),
        .walk_req     (req_held),
        .walk_pte     (walk_pte),
        .walk_super   (walk_super),
        .page_fault   (walk_page_fault),
        .bus_err      (walk_bus_err),
        .pa_valid     (pa_valid),
        .pa           (pa),
        .pa_bad       (pa_bad)
    );

endmodule

`default_nettype wire

// ==== tb/mmu_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_mem_model (
    input  wire                      clk,
    input  wire                      rstn,
    input  mem_rd_pkg::mem_rd_req_t  rd_req,
    output logic                     ar_ready,
    output mem_rd_pkg::mem_rd_rsp_t  rd_rsp
);

    localparam int DEPTH = 4096;

    // word array covers physical 0x0000 to 0x3fff
    logic [31:0] words [DEPTH];
    logic        bad   [DEPTH];
    integer      seed;
    logic [1:0]  ar_wait;
    logic [1:0]  rsp_wait;
    logic        pending;
    logic [11:0] idx_q;

    initial begin
        seed = 30;
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = 32'h0;
            bad[i]   = 1'b0;
        end
    end

    assign ar_ready = (ar_wait == 2'd0);

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_wait  <= 2'd0;
            rsp_wait <= 2'd0;
            pending  <= 1'b0;
            rd_rsp   <= '0;
        end else begin
            rd_rsp.valid <= 1'b0;
            if (pending) begin
                if (rsp_wait == 2'd1) begin
                    rd_rsp.valid <= 1'b1;
                    rd_rsp.data  <= words[idx_q];
                    rd_rsp.err   <= bad[idx_q];
                    pending      <= 1'b0;
                end else begin
                    rsp_wait <= rsp_wait - 2'd1;
                end
            end
            if (rd_req.valid && ar_ready) begin
                idx_q    <= rd_req.addr[13:2];
                pending  <= 1'b1;
                rsp_wait <= 2'(1 + {$random(seed)} % 3);
                ar_wait  <= 2'({$random(seed)} % 4);
            end else if (rd_req.valid && ar_wait != 2'd0) begin
                ar_wait <= ar_wait - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

    import sv32_pkg::*;
    import mem_rd_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_TESTS  = 9;
    localparam logic [21:0] ROOT_PPN   = 22'h00001;
    localparam logic [21:0] L0_PPN     = 22'h00002;

    // pte flag bits
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic            clk;
    logic            rstn;
    logic            va_valid;
    logic [31:0]     va;
    logic            access_w;
    logic            access_x;
    prv_e            prv;
    logic            mprv;
    prv_e            mpp;
    logic            sum;
    satp_mode_e      satp_mode;
    logic [21:0]     satp_ppn;
    logic            flush;
    logic            mem_rd_ar_ready;
    mem_rd_rsp_t     mem_rd_rsp;
    logic            va_ready;
    mem_rd_req_t     mem_rd_req;
    logic            pa_valid;
    logic [PA_W-1:0] pa;
    logic [1:0]      pa_bad;

    logic [PA_W-1:0] res_pa;
    logic [1:0]      res_bad;
    int              res_cycles;
    int              res_reads;
    int              res_first;
    int              rd_count = 0;
    logic [PA_W-1:0] rd_addrs [$];

    mmu_top u_dut (
        .clk             (clk),
        .rstn            (rstn),
        .va_valid        (va_valid),
        .va              (va),
        .access_w        (access_w),
        .access_x        (access_x),
        .prv             (prv),
        .mprv            (mprv),
        .mpp             (mpp),
        .sum             (sum),
        .satp_mode       (satp_mode),
        .satp_ppn        (satp_ppn),
        .flush           (flush),
        .mem_rd_ar_ready (mem_rd_ar_ready),
        .mem_rd_rsp      (mem_rd_rsp),
        .va_ready        (va_ready),
        .mem_rd_req      (mem_rd_req),
        .pa_valid        (pa_valid),
        .pa              (pa),
        .pa_bad          (pa_bad)
    );

    mmu_mem_model u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .rd_req   (mem_rd_req),
        .ar_ready (mem_rd_ar_ready),
        .rd_rsp   (mem_rd_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // address handshakes sampled mid-cycle
    always @(negedge clk) begin
        if (mem_rd_req.valid && mem_rd_ar_ready) begin
            rd_addrs.push_back(mem_rd_req.addr);
            rd_count <= rd_count + 1;
        end
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles without the tests finishing",
                 NUM_TESTS * 200);
        $display("Test failures found");
        $fatal(1, "simulation timed out");
    end

    task automatic check(input string name, input logic [PA_W-1:0] expected,
                         input logic [PA_W-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [PA_W-1:0] pte_addr(input logic [21:0] ppn, input logic [9:0] vpn);
        return {ppn, 12'h000} + {22'h0, vpn, 2'b00};
    endfunction

    task automatic write_pte(input logic [PA_W-1:0] addr, input logic [31:0] value);
        u_mem.words[addr[13:2]] = value;
    endtask

    task automatic mark_bad(input logic [PA_W-1:0] addr);
        u_mem.bad[addr[13:2]] = 1'b1;
    endtask

    task automatic build_tables();
        write_pte(pte_addr(ROOT_PPN, 10'h001), make_pte(L0_PPN, F_V));
        write_pte(pte_addr(L0_PPN, 10'h005), make_pte(22'h12345, F_R | F_W | F_A | F_D | F_V));
        // dirty bit clear
        write_pte(pte_addr(L0_PPN, 10'h006), make_pte(22'h00077, F_R | F_W | F_A | F_V));
        write_pte(pte_addr(L0_PPN, 10'h007),
                  make_pte(22'h00078, F_R | F_W | F_A | F_D | F_U | F_V));
        write_pte(pte_addr(L0_PPN, 10'h008), make_pte(22'h00079, F_R | F_A | F_D | F_V));
        write_pte(pte_addr(ROOT_PPN, 10'h002),
                  make_pte({12'h0ab, 10'h000}, F_R | F_W | F_X | F_A | F_D | F_V));
        // superpage with nonzero ppn0
        write_pte(pte_addr(ROOT_PPN, 10'h003), make_pte({12'h0ac, 10'h001}, F_R | F_A | F_D | F_V));
        write_pte(pte_addr(ROOT_PPN, 10'h004), 32'h0);
        mark_bad(pte_addr(ROOT_PPN, 10'h005));
    endtask

    task automatic issue_request(input string name, input logic [31:0] addr, input logic w,
                                 input logic x, input prv_e p, input logic mprv_in,
                                 input prv_e mpp_in, input logic sum_in,
                                 input satp_mode_e mode);
        int reads_start;
        reads_start = rd_count;
        @(posedge clk);
        #1;
        va_valid  = 1'b1;
        va        = addr;
        access_w  = w;
        access_x  = x;
        prv       = p;
        mprv      = mprv_in;
        mpp       = mpp_in;
        sum       = sum_in;
        satp_mode = mode;
        @(negedge clk);
        while (!va_ready) begin
            @(negedge clk);
        end
        // accepted on this edge
        @(posedge clk);
        #1;
        va_valid   = 1'b0;
        res_cycles = 0;
        do begin
            @(negedge clk);
            res_cycles++;
        end while (!pa_valid);
        res_pa    = pa;
        res_bad   = pa_bad;
        res_first = reads_start;
        res_reads = rd_count - reads_start;
        check({name, " va_ready"}, 34'd1, 34'(va_ready));
    endtask

    task automatic expect_result(input string name, input logic [PA_W-1:0] exp_pa,
                                 input logic [1:0] exp_bad);
        check({name, " pa"}, exp_pa, res_pa);
        check({name, " pa_bad"}, 34'(exp_bad), 34'(res_bad));
    endtask

    task automatic expect_read_addr(input string name, input int n,
                                    input logic [PA_W-1:0] exp_addr);
        check(name, exp_addr, rd_addrs[res_first + n]);
    endtask

    task automatic flush_entry();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic reset_state();
        @(negedge clk);
        check("reset va_ready", 34'd1, 34'(va_ready));
        check("reset pa_valid", 34'd0, 34'(pa_valid));
        check("reset ar valid", 34'd0, 34'(mem_rd_req.valid));
    endtask

    task automatic bare_mode_passthrough();
        issue_request("bare", 32'hffff_f123, 1'b0, 1'b0, PRV_S, 1'b0, PRV_U, 1'b0, MODE_BARE);
        expect_result("bare", {2'b00, 32'hffff_f123}, 2'b00);
        check("bare latency", 34'd1, 34'(res_cycles));
        check("bare reads", 34'd0, 34'(res_reads));
    endtask

    task automatic machine_mode_passthrough();
        issue_request("machine", 32'h8040_2abc, 1'b1, 1'b0, PRV_M, 1'b0, PRV_U, 1'b0, MODE_SV32);
        expect_result("machine", {2'b00, 32'h8040_2abc}, 2'b00);
        check("machine latency", 34'd1, 34'(res_cycles));
        check("machine reads", 34'd0, 34'(res_reads));
    endtask

    task automatic two_level_walk();
        issue_request("walk4k rd", {10'h001, 10'h005, 12'habc}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        expect_result("walk4k rd", {22'h12345, 12'habc}, 2'b00);
        check("walk4k rd reads", 34'd2, 34'(res_reads));
        expect_read_addr("walk4k rd l1 addr", 0, pte_addr(ROOT_PPN, 10'h001));
        expect_read_addr("walk4k rd l0 addr", 1, pte_addr(L0_PPN, 10'h005));
        // same page now served from the entry
        issue_request("walk4k wr", {10'h001, 10'h005, 12'h008}, 1'b1, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        expect_result("walk4k wr", {22'h12345, 12'h008}, 2'b00);
        check("walk4k wr latency", 34'd1, 34'(res_cycles));
    endtask

    task automatic superpage_walk();
        issue_request("super", {10'h002, 10'h155, 12'h321}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        expect_result("super", {12'h0ab, 10'h155, 12'h321}, 2'b00);
        check("super reads", 34'd1, 34'(res_reads));
        expect_read_addr("super l1 addr", 0, pte_addr(ROOT_PPN, 10'h002));
    endtask

    task automatic leaf_faults();
        issue_request("dirty clear", {10'h001, 10'h006, 12'h010}, 1'b1, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("dirty clear pa_bad", 34'd1, 34'(res_bad));
        issue_request("user no sum", {10'h001, 10'h007, 12'h020}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("user no sum pa_bad", 34'd1, 34'(res_bad));
        issue_request("u on s page", {10'h001, 10'h008, 12'h030}, 1'b0, 1'b0, PRV_U, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("u on s page pa_bad", 34'd1, 34'(res_bad));
        issue_request("misaligned", {10'h003, 10'h011, 12'h040}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("misaligned pa_bad", 34'd1, 34'(res_bad));
        issue_request("invalid l1", {10'h004, 10'h000, 12'h050}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("invalid l1 pa_bad", 34'd1, 34'(res_bad));
    endtask

    task automatic mprv_translation();
        issue_request("mprv rd", {10'h001, 10'h005, 12'h044}, 1'b0, 1'b0, PRV_M, 1'b1,
                      PRV_S, 1'b0, MODE_SV32);
        expect_result("mprv rd", {22'h12345, 12'h044}, 2'b00);
        // fetches ignore mprv and stay in M
        issue_request("mprv exec", {10'h001, 10'h005, 12'h048}, 1'b0, 1'b1, PRV_M, 1'b1,
                      PRV_S, 1'b0, MODE_SV32);
        expect_result("mprv exec", {2'b00, 10'h001, 10'h005, 12'h048}, 2'b00);
        check("mprv exec latency", 34'd1, 34'(res_cycles));
        check("mprv exec reads", 34'd0, 34'(res_reads));
    endtask

    task automatic read_error_response();
        issue_request("bus err", {10'h005, 10'h000, 12'h000}, 1'b0, 1'b0, PRV_S, 1'b0,
                      PRV_U, 1'b0, MODE_SV32);
        check("bus err pa_bad", 34'd2, 34'(res_bad));
    endtask

    task automatic cache_hit_and_flush();
        logic [31:0] addr;
        addr = {10'h001, 10'h005, 12'h100};
        flush_entry();
        issue_request("cache fill", addr, 1'b0, 1'b0, PRV_S, 1'b0, PRV_U, 1'b0, MODE_SV32);
        expect_result("cache fill", {22'h12345, 12'h100}, 2'b00);
        check("cache fill reads", 34'd2, 34'(res_reads));
        issue_request("cache hit", addr, 1'b0, 1'b0, PRV_S, 1'b0, PRV_U, 1'b0, MODE_SV32);
        expect_result("cache hit", {22'h12345, 12'h100}, 2'b00);
        check("cache hit latency", 34'd1, 34'(res_cycles));
        check("cache hit reads", 34'd0, 34'(res_reads));
        flush_entry();
        issue_request("after flush", addr, 1'b0, 1'b0, PRV_S, 1'b0, PRV_U, 1'b0, MODE_SV32);
        expect_result("after flush", {22'h12345, 12'h100}, 2'b00);
        check("after flush reads", 34'd2, 34'(res_reads));
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        va_valid  = 1'b0;
        va        = '0;
        access_w  = 1'b0;
        access_x  = 1'b0;
        prv       = PRV_S;
        mprv      = 1'b0;
        mpp       = PRV_U;
        sum       = 1'b0;
        satp_mode = MODE_SV32;
        satp_ppn  = ROOT_PPN;
        flush     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        build_tables();
        reset_state();
        bare_mode_passthrough();
        machine_mode_passthrough();
        two_level_walk();
        superpage_walk();
        leaf_faults();
        mprv_translation();
        read_error_response();
        cache_hit_and_flush();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/sv32_pkg.sv
source/mem_rd_pkg.sv
source/mmu_req_capture.sv
source/mmu_last_entry.sv
source/mmu_pte_check.sv
source/mmu_walker.sv
source/mmu_result.sv
source/mmu_top.sv
tb/mmu_mem_model.sv
tb/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the MMU testbench, then scan the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module mmu_tb -o mmu_sim \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1
exit 0
